/* Makefile */
TOP := router_stats_regs_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -o sim
	@out="$$(./obj_dir/sim)"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir

/* dv/router_stats_tb_tasks.svh */
/* Router statistics testbench helpers
   Bus tasks, register reference model and typed compare tasks */

`ifndef ROUTER_STATS_TB_TASKS_SVH
`define ROUTER_STATS_TB_TASKS_SVH

task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
endtask

task automatic check_word(input string what, input reg_word_t got, input reg_word_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
    end
endtask

task automatic check_resp(input string what, input reg_resp_t got, input reg_resp_t exp);
    if (got !== exp) begin
        fail_run($sformatf("Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp));
    end
endtask

////////////////////////////////////////////////////////////
// Reference model

// Port in bits 15:8, counter index in bits 7:0
function automatic counter_t window_value(input reg_word_t sel, input bit ing);
    int port;
    int idx;
    port = int'(sel[15:8]);
    idx  = int'(sel[7:0]);
    if (port >= NUM_PORTS) begin
        return '0;
    end
    if (ing) begin
        return (idx < ING_CNTRS) ? exp_ing_snap[port][idx] : '0;
    end
    return (idx < EGR_CNTRS) ? exp_egr_snap[port][idx] : '0;
endfunction

function automatic reg_word_t expected_word(input int word);
    case (word)
        ADDR_VERSION_ID:           return {16'h0100, 16'd10};
        ADDR_PARAMS0:              return {8'd0, 8'd64, 8'd11, 8'd11};
        ADDR_PARAMS1:              return {16'd10000, 16'd2000};
        ADDR_ING_PORT_ENABLE_CON:  return exp_ing_en;
        ADDR_EGR_PORT_ENABLE_CON:  return exp_egr_en;
        // Connected inputs are looped back from the enables
        ADDR_ING_PORT_ENABLE_STAT: return exp_ing_en;
        ADDR_EGR_PORT_ENABLE_STAT: return exp_egr_en;
        ADDR_ING_CNTRS_SAMPLE_CON: return exp_ing_sample;
        ADDR_ING_CNTRS_READ_SEL:   return exp_ing_sel;
        ADDR_ING_CNTRS_READ_DATA:  return window_value(exp_ing_sel, 1'b1);
        ADDR_EGR_CNTRS_SAMPLE_CON: return exp_egr_sample;
        ADDR_EGR_CNTRS_READ_SEL:   return exp_egr_sel;
        ADDR_EGR_CNTRS_READ_DATA:  return window_value(exp_egr_sel, 1'b0);
        default:                   return '0;
    endcase
endfunction

function automatic reg_resp_t expected_resp(input int word);
    return (word < TOTAL_REGS) ? RESP_OKAY : RESP_SLAVE_ERROR;
endfunction

// A rising sample bit copies profile and event counts and restarts the events
function automatic void model_write(input int word, input reg_word_t data);
    for (int p = 0; p < NUM_PORTS; p++) begin
        if (word == ADDR_ING_CNTRS_SAMPLE_CON && data[p] && !exp_ing_sample[p]) begin
            for (int c = 0; c < NUM_PROFILE_CNTRS; c++) begin
                exp_ing_snap[p][c] = ing_profile_cnts[p][c];
            end
            for (int e = 0; e < 2; e++) begin
                exp_ing_snap[p][NUM_PROFILE_CNTRS+e] = counter_t'(ing_events[p][e]);
                ing_events[p][e] = 0;
            end
        end
        if (word == ADDR_EGR_CNTRS_SAMPLE_CON && data[p] && !exp_egr_sample[p]) begin
            for (int c = 0; c < NUM_PROFILE_CNTRS; c++) begin
                exp_egr_snap[p][c] = egr_profile_cnts[p][c];
            end
            exp_egr_snap[p][NUM_PROFILE_CNTRS] = counter_t'(egr_events[p][0]);
            egr_events[p][0] = 0;
        end
    end
    case (word)
        ADDR_ING_PORT_ENABLE_CON:  exp_ing_en     = data & PORT_MASK;
        ADDR_EGR_PORT_ENABLE_CON:  exp_egr_en     = data & PORT_MASK;
        ADDR_ING_CNTRS_SAMPLE_CON: exp_ing_sample = data;
        ADDR_ING_CNTRS_READ_SEL:   exp_ing_sel    = data;
        ADDR_EGR_CNTRS_SAMPLE_CON: exp_egr_sample = data;
        ADDR_EGR_CNTRS_READ_SEL:   exp_egr_sel    = data;
        default: ;
    endcase
endfunction

////////////////////////////////////////////////////////////
// Bus tasks run from a falling edge

task automatic bus_read(input int word);
    int waited;
    exp_rd_word_q.push_back(expected_word(word));
    exp_rd_resp_q.push_back(expected_resp(word));
    address = reg_addr_t'(word * 4);
    read    = 1'b1;
    @(negedge core_clk_ifc);
    read   = 1'b0;
    waited = 1;
    while (!readdatavalid) begin
        if (waited >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: readdatavalid never came after a read");
        end
        @(negedge core_clk_ifc);
        waited++;
    end
    if (waited != 1) begin
        fail_run($sformatf("Error at %0d ns: read latency %0d cycles", $time, waited));
    end
endtask

task automatic bus_write(input int word, input reg_word_t data);
    int waited;
    exp_wr_resp_q.push_back(expected_resp(word));
    model_write(word, data);
    address   = reg_addr_t'(word * 4);
    writedata = data;
    write     = 1'b1;
    @(negedge core_clk_ifc);
    write  = 1'b0;
    waited = 1;
    while (!writeresponsevalid) begin
        if (waited >= TIMEOUT_CYCLES) begin
            fail_run("Timeout: writeresponsevalid never came after a write");
        end
        @(negedge core_clk_ifc);
        waited++;
    end
    if (waited != 1) begin
        fail_run($sformatf("Error at %0d ns: write response latency %0d cycles", $time, waited));
    end
endtask

`endif

/* dv/router_stats_regs_tb.sv */
/* Testbench for the router statistics register block
   Drives bus, profile counts and events, and checks every bus response */

`default_nettype none
`timescale 1ns/1ps

module router_stats_regs_tb
    import router_regs_pkg::*;
    import router_stats_pkg::*;
();

    localparam int NUM_PORTS      = 11;
    localparam int ING_CNTRS      = 5;
    localparam int EGR_CNTRS      = 4;
    localparam int TIMEOUT_CYCLES = 20;
    localparam port_mask_t PORT_MASK = 32'h0000_07ff;
    localparam int RO_WORDS [7] = '{ADDR_VERSION_ID, ADDR_PARAMS0, ADDR_PARAMS1,
                                    ADDR_ING_PORT_ENABLE_STAT, ADDR_EGR_PORT_ENABLE_STAT,
                                    ADDR_ING_CNTRS_READ_DATA, ADDR_EGR_CNTRS_READ_DATA};

    logic       core_clk_ifc;
    logic       peripheral_sresetn_core;
    reg_addr_t  address;
    logic       read;
    logic       write;
    reg_word_t  writedata;
    reg_word_t  readdata;
    logic       readdatavalid;
    reg_resp_t  response;
    logic       writeresponsevalid;
    port_mask_t ing_phys_ports_enable;
    port_mask_t egr_phys_ports_enable;
    port_mask_t ing_async_fifo_overflow;
    port_mask_t ing_buf_overflow;
    port_mask_t egr_buf_full_drop;
    counter_t [NUM_PORTS-1:0][NUM_PROFILE_CNTRS-1:0] ing_profile_cnts;
    counter_t [NUM_PORTS-1:0][NUM_PROFILE_CNTRS-1:0] egr_profile_cnts;

    // Reference model state
    port_mask_t exp_ing_en;
    port_mask_t exp_egr_en;
    reg_word_t  exp_ing_sample;
    reg_word_t  exp_egr_sample;
    reg_word_t  exp_ing_sel;
    reg_word_t  exp_egr_sel;
    counter_t   exp_ing_snap [NUM_PORTS][ING_CNTRS];
    counter_t   exp_egr_snap [NUM_PORTS][EGR_CNTRS];
    int         ing_events [NUM_PORTS][2];
    int         egr_events [NUM_PORTS][1];

    // Outstanding responses in issue order
    reg_word_t  exp_rd_word_q [$];
    reg_resp_t  exp_rd_resp_q [$];
    reg_resp_t  exp_wr_resp_q [$];

    `include "router_stats_tb_tasks.svh"

    router_stats_regs router_stats_regs_inst (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .address                 ( address                 ),
        .read                    ( read                    ),
        .write                   ( write                   ),
        .writedata               ( writedata               ),
        .readdata                ( readdata                ),
        .readdatavalid           ( readdatavalid           ),
        .response                ( response                ),
        .writeresponsevalid      ( writeresponsevalid      ),
        .ing_phys_ports_enable   ( ing_phys_ports_enable   ),
        .ing_ports_connected     ( ing_phys_ports_enable   ),
        .ing_profile_cnts        ( ing_profile_cnts        ),
        .ing_async_fifo_overflow ( ing_async_fifo_overflow ),
        .ing_buf_overflow        ( ing_buf_overflow        ),
        .egr_phys_ports_enable   ( egr_phys_ports_enable   ),
        .egr_ports_connected     ( egr_phys_ports_enable   ),
        .egr_profile_cnts        ( egr_profile_cnts        ),
        .egr_buf_full_drop       ( egr_buf_full_drop       )
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #5 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////////////////////////
    // Checking process samples outputs on the falling edge
    always @(negedge core_clk_ifc) begin
        if (readdatavalid) begin
            if (exp_rd_word_q.size() == 0) begin
                fail_run("readdatavalid came with no read outstanding");
            end else begin
                check_word("readdata", readdata, exp_rd_word_q.pop_front());
                check_resp("read response", response, exp_rd_resp_q.pop_front());
            end
        end
        if (writeresponsevalid) begin
            if (exp_wr_resp_q.size() == 0) begin
                fail_run("writeresponsevalid came with no write outstanding");
            end else begin
                check_resp("write response", response, exp_wr_resp_q.pop_front());
            end
        end
    end

    task automatic randomize_profiles();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int c = 0; c < NUM_PROFILE_CNTRS; c++) begin
                ing_profile_cnts[p][c] = $urandom();
                egr_profile_cnts[p][c] = $urandom();
            end
        end
    endtask

    // Bit goes low first so every masked port sees a rising edge
    task automatic sample_ports(input reg_word_t ing_mask, input reg_word_t egr_mask);
        bus_write(ADDR_ING_CNTRS_SAMPLE_CON, '0);
        bus_write(ADDR_ING_CNTRS_SAMPLE_CON, ing_mask);
        bus_write(ADDR_EGR_CNTRS_SAMPLE_CON, '0);
        bus_write(ADDR_EGR_CNTRS_SAMPLE_CON, egr_mask);
        repeat (2) @(negedge core_clk_ifc);
    endtask

    task automatic read_windows();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int c = 0; c < ING_CNTRS; c++) begin
                bus_write(ADDR_ING_CNTRS_READ_SEL, {16'h0, 8'(p), 8'(c)});
                bus_read(ADDR_ING_CNTRS_READ_DATA);
            end
            for (int c = 0; c < EGR_CNTRS; c++) begin
                bus_write(ADDR_EGR_CNTRS_READ_SEL, {16'h0, 8'(p), 8'(c)});
                bus_read(ADDR_EGR_CNTRS_READ_DATA);
            end
        end
    endtask

    // One-cycle pulses with a distinct count per port
    task automatic pulse_events();
        for (int k = 0; k < NUM_PORTS + 1; k++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                ing_async_fifo_overflow[p] = (k < p + 1);
                ing_buf_overflow[p]        = (k < p + 2);
                egr_buf_full_drop[p]       = (k < NUM_PORTS - p);
            end
            @(negedge core_clk_ifc);
            ing_async_fifo_overflow = '0;
            ing_buf_overflow        = '0;
            egr_buf_full_drop       = '0;
            @(negedge core_clk_ifc);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            ing_events[p][0] += p + 1;
            ing_events[p][1] += p + 2;
            egr_events[p][0] += NUM_PORTS - p;
        end
        repeat (3) @(negedge core_clk_ifc);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus sequence
    initial begin
        int word;
        void'($urandom(32'hc455));
        peripheral_sresetn_core = 1'b0;
        address                 = '0;
        read                    = 1'b0;
        write                   = 1'b0;
        writedata               = '0;
        ing_async_fifo_overflow = '0;
        ing_buf_overflow        = '0;
        egr_buf_full_drop       = '0;
        ing_profile_cnts        = '0;
        egr_profile_cnts        = '0;
        exp_ing_en     = PORT_MASK;
        exp_egr_en     = PORT_MASK;
        exp_ing_sample = '0;
        exp_egr_sample = '0;
        exp_ing_sel    = '0;
        exp_egr_sel    = '0;
        exp_ing_snap   = '{default: '0};
        exp_egr_snap   = '{default: '0};
        ing_events     = '{default: 0};
        egr_events     = '{default: 0};
        repeat (8) @(negedge core_clk_ifc);
        peripheral_sresetn_core = 1'b1;
        @(negedge core_clk_ifc);

        // Reset values of the whole map
        for (int w = 0; w < TOTAL_REGS; w++) begin
            bus_read(w);
        end

        // Enables and status
        bus_write(ADDR_ING_PORT_ENABLE_CON, $urandom());
        bus_write(ADDR_EGR_PORT_ENABLE_CON, $urandom());
        bus_read(ADDR_ING_PORT_ENABLE_CON);
        bus_read(ADDR_EGR_PORT_ENABLE_CON);
        repeat (3) @(negedge core_clk_ifc);
        bus_read(ADDR_ING_PORT_ENABLE_STAT);
        bus_read(ADDR_EGR_PORT_ENABLE_STAT);

        // Profile counts and a partial resample
        randomize_profiles();
        sample_ports('1, '1);
        read_windows();
        randomize_profiles();
        sample_ports($urandom(), $urandom());
        read_windows();

        // Event counts and a sample with no events
        pulse_events();
        sample_ports('1, '1);
        read_windows();
        sample_ports('1, '1);
        read_windows();

        // Unmapped addresses
        repeat (8) begin
            word = TOTAL_REGS + int'($urandom() % (8192 - TOTAL_REGS));
            if ($urandom() % 2 == 0) begin
                bus_read(word);
            end else begin
                bus_write(word, $urandom());
            end
        end

        // Out-of-range port and index
        repeat (4) begin
            bus_write(ADDR_ING_CNTRS_READ_SEL,
                      {16'h0, 8'(11 + $urandom() % 245), 8'($urandom() % 5)});
            bus_read(ADDR_ING_CNTRS_READ_DATA);
            bus_write(ADDR_EGR_CNTRS_READ_SEL,
                      {16'h0, 8'(11 + $urandom() % 245), 8'($urandom() % 4)});
            bus_read(ADDR_EGR_CNTRS_READ_DATA);
            bus_write(ADDR_EGR_CNTRS_READ_SEL,
                      {16'h0, 8'($urandom() % 11), 8'(4 + $urandom() % 252)});
            bus_read(ADDR_EGR_CNTRS_READ_DATA);
            bus_write(ADDR_ING_CNTRS_READ_SEL,
                      {16'h0, 8'($urandom() % 11), 8'(5 + $urandom() % 251)});
            bus_read(ADDR_ING_CNTRS_READ_DATA);
        end

        // Read-only words ignore writes
        foreach (RO_WORDS[i]) begin
            bus_write(RO_WORDS[i], $urandom());
            bus_read(RO_WORDS[i]);
        end
        for (int w = 0; w < TOTAL_REGS; w++) begin
            bus_read(w);
        end

        repeat (2) @(negedge core_clk_ifc);
        if (exp_rd_word_q.size() != 0 || exp_wr_resp_q.size() != 0) begin
            fail_run("Some bus responses were never seen");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hdl/counter_snapshot.sv */
/* Counter snapshot store for one direction
   Captures profile and event counts on a rising sample bit, read through a select window */

`default_nettype none
`timescale 1ns/1ps

module counter_snapshot
    import router_regs_pkg::*;
    import router_stats_pkg::*;
#(
    parameter int NUM_PORTS  = 11,
    parameter int NUM_EVENTS = 2
) (
    input  wire logic       core_clk_ifc,
    input  wire logic       peripheral_sresetn_core,
    input  wire port_mask_t sample,
    input  wire reg_word_t  read_sel,
    input  wire counter_t [NUM_PORTS-1:0][NUM_PROFILE_CNTRS-1:0] profile_cnts,
    input  wire counter_t [NUM_PORTS-1:0][NUM_EVENTS-1:0]        event_counts,
    output port_mask_t      sample_stb,
    output counter_t        read_data
);

    localparam int NUM_CNTRS = NUM_PROFILE_CNTRS + NUM_EVENTS;
    localparam port_mask_t PORT_MASK = port_mask_t'((64'd1 << NUM_PORTS) - 64'd1);

    port_mask_t sample_d;
    counter_t [NUM_PORTS-1:0][NUM_CNTRS-1:0] snap;
    sel_field_t sel_port;
    sel_field_t sel_idx;

    ////////////////////////////////////////////////////////////
    // Sample edge detection
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            sample_d <= '0;
        end else begin
            sample_d <= sample;
        end
    end

    // Only a 0 to 1 change captures, so a held bit samples once
    assign sample_stb = sample & ~sample_d & PORT_MASK;

    ////////////////////////////////////////////////////////////
    // Snapshot storage
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            snap <= '0;
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (sample_stb[p]) begin
                    snap[p][PKT_CNT]  <= profile_cnts[p][PKT_CNT];
                    snap[p][BYTE_CNT] <= profile_cnts[p][BYTE_CNT];
                    snap[p][ERR_CNT]  <= profile_cnts[p][ERR_CNT];
                    for (int e = 0; e < NUM_EVENTS; e++) begin
                        snap[p][FIRST_EVENT_CNT+e] <= event_counts[p][e];
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Select window
    assign sel_port = read_sel[SEL_PORT_MSB:SEL_PORT_LSB];
    assign sel_idx  = read_sel[SEL_IDX_MSB:SEL_IDX_LSB];

    // Out-of-range port or index matches nothing and reads zero
    always_comb begin
        read_data = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int c = 0; c < NUM_CNTRS; c++) begin
                if (sel_port == sel_field_t'(p) && sel_idx == sel_field_t'(c)) begin
                    read_data = snap[p][c];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/port_event_counters.sv */
/* Per-port event counters
   Counts rising edges of each event input, restarting at zero on a sample strobe */

`default_nettype none
`timescale 1ns/1ps

module port_event_counters
    import router_stats_pkg::*;
#(
    parameter int NUM_PORTS  = 11,
    parameter int NUM_EVENTS = 2
) (
    input  wire logic                          core_clk_ifc,
    input  wire logic                          peripheral_sresetn_core,
    input  wire port_mask_t [NUM_EVENTS-1:0]   events,
    input  wire port_mask_t                    sample_stb,
    output counter_t [NUM_PORTS-1:0][NUM_EVENTS-1:0] event_counts
);

    // Registered input and its previous value
    port_mask_t [NUM_EVENTS-1:0] events_q;
    port_mask_t [NUM_EVENTS-1:0] events_qq;

    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            events_q     <= '0;
            events_qq    <= '0;
            event_counts <= '0;
        end else begin
            events_q  <= events;
            events_qq <= events_q;
            for (int p = 0; p < NUM_PORTS; p++) begin
                for (int e = 0; e < NUM_EVENTS; e++) begin
                    // Sampling wins over an edge in the same cycle
                    if (sample_stb[p]) begin
                        event_counts[p][e] <= '0;
                    end else if (events_q[e][p] && !events_qq[e][p]) begin
                        event_counts[p][e] <= event_counts[p][e] + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/router_csr_slave.sv */
/* Avalon-MM style slave for the router statistics block
   Holds the control registers and answers reads and writes one cycle later */

`default_nettype none
`timescale 1ns/1ps

module router_csr_slave
    import router_regs_pkg::*;
    import router_stats_pkg::*;
#(
    parameter int NUM_ING_PORTS   = 11,
    parameter int NUM_EGR_PORTS   = 11,
    parameter int MTU_BYTES       = 2000,
    parameter int DATA_BYTES      = 64,
    parameter int CLOCK_PERIOD_PS = 10000,
    parameter int MODULE_ID       = 10
) (
    input  wire logic       core_clk_ifc,
    input  wire logic       peripheral_sresetn_core,

    input  wire reg_addr_t  address,
    input  wire logic       read,
    input  wire logic       write,
    input  wire reg_word_t  writedata,
    output reg_word_t       readdata,
    output logic            readdatavalid,
    output reg_resp_t       response,
    output logic            writeresponsevalid,

    output port_mask_t      ing_phys_ports_enable,
    output port_mask_t      egr_phys_ports_enable,
    input  wire port_mask_t ing_ports_connected,
    input  wire port_mask_t egr_ports_connected,

    output port_mask_t      ing_sample,
    output reg_word_t       ing_read_sel,
    input  wire counter_t   ing_read_data,
    output port_mask_t      egr_sample,
    output reg_word_t       egr_read_sel,
    input  wire counter_t   egr_read_data
);

    ////////////////////////////////////////////////////////////
    // Constant words
    localparam port_mask_t ING_MASK = port_mask_t'((64'd1 << NUM_ING_PORTS) - 64'd1);
    localparam port_mask_t EGR_MASK = port_mask_t'((64'd1 << NUM_EGR_PORTS) - 64'd1);

    localparam reg_word_t VERSION_ID_WORD = {MODULE_VERSION, 16'(MODULE_ID)};
    localparam reg_word_t PARAMS0_WORD    = {8'd0, 8'(DATA_BYTES), 8'(NUM_EGR_PORTS),
                                             8'(NUM_ING_PORTS)};
    localparam reg_word_t PARAMS1_WORD    = {16'(CLOCK_PERIOD_PS), 16'(MTU_BYTES)};

    logic [12:0] word_addr;
    logic        addr_ok;
    reg_word_t   rd_word;

    // Byte address to word address, low two bits ignored
    assign word_addr = address[14:2];
    assign addr_ok   = int'(word_addr) < TOTAL_REGS;

    ////////////////////////////////////////////////////////////
    // Writable registers
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            ing_phys_ports_enable <= ING_MASK;
            egr_phys_ports_enable <= EGR_MASK;
            ing_sample            <= '0;
            ing_read_sel          <= '0;
            egr_sample            <= '0;
            egr_read_sel          <= '0;
        end else if (write) begin
            case (word_addr)
                ADDR_ING_PORT_ENABLE_CON:  ing_phys_ports_enable <= writedata & ING_MASK;
                ADDR_EGR_PORT_ENABLE_CON:  egr_phys_ports_enable <= writedata & EGR_MASK;
                ADDR_ING_CNTRS_SAMPLE_CON: ing_sample            <= writedata;
                ADDR_ING_CNTRS_READ_SEL:   ing_read_sel          <= writedata;
                ADDR_EGR_CNTRS_SAMPLE_CON: egr_sample            <= writedata;
                ADDR_EGR_CNTRS_READ_SEL:   egr_read_sel          <= writedata;
                // Read-only and unmapped words keep their value
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Read multiplexer
    always_comb begin
        rd_word = '0;
        case (word_addr)
            ADDR_VERSION_ID:           rd_word = VERSION_ID_WORD;
            ADDR_PARAMS0:              rd_word = PARAMS0_WORD;
            ADDR_PARAMS1:              rd_word = PARAMS1_WORD;
            ADDR_ING_PORT_ENABLE_CON:  rd_word = ing_phys_ports_enable;
            ADDR_EGR_PORT_ENABLE_CON:  rd_word = egr_phys_ports_enable;
            ADDR_ING_PORT_ENABLE_STAT: rd_word = ing_ports_connected & ING_MASK;
            ADDR_EGR_PORT_ENABLE_STAT: rd_word = egr_ports_connected & EGR_MASK;
            ADDR_ING_CNTRS_SAMPLE_CON: rd_word = ing_sample;
            ADDR_ING_CNTRS_READ_SEL:   rd_word = ing_read_sel;
            ADDR_ING_CNTRS_READ_DATA:  rd_word = ing_read_data;
            ADDR_EGR_CNTRS_SAMPLE_CON: rd_word = egr_sample;
            ADDR_EGR_CNTRS_READ_SEL:   rd_word = egr_read_sel;
            ADDR_EGR_CNTRS_READ_DATA:  rd_word = egr_read_data;
            default:                   rd_word = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Responses, one cycle after the strobe
    always_ff @(posedge core_clk_ifc) begin
        if (!peripheral_sresetn_core) begin
            readdatavalid      <= 1'b0;
            writeresponsevalid <= 1'b0;
        end else begin
            readdatavalid      <= read;
            writeresponsevalid <= write;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (read) begin
            readdata <= rd_word;
        end
        if (read || write) begin
            response <= addr_ok ? RESP_OKAY : RESP_SLAVE_ERROR;
        end
    end

endmodule

`default_nettype wire

/* hdl/router_regs_pkg.sv */
/* Router statistics register map
   Word addresses, select field layout and bus response codes */

`default_nettype none

package router_regs_pkg;

    typedef logic [14:0] reg_addr_t;
    typedef logic [31:0] reg_word_t;
    typedef logic [1:0]  reg_resp_t;

    ////////////////////////////////////////////////////////////
    // Word addresses
    localparam int ADDR_VERSION_ID           = 0;
    localparam int ADDR_PARAMS0              = 1;
    localparam int ADDR_PARAMS1              = 2;
    localparam int ADDR_ING_PORT_ENABLE_CON  = 3;
    localparam int ADDR_EGR_PORT_ENABLE_CON  = 4;
    localparam int ADDR_ING_PORT_ENABLE_STAT = 5;
    localparam int ADDR_EGR_PORT_ENABLE_STAT = 6;
    localparam int ADDR_ING_CNTRS_SAMPLE_CON = 7;
    localparam int ADDR_ING_CNTRS_READ_SEL   = 8;
    localparam int ADDR_ING_CNTRS_READ_DATA  = 9;
    localparam int ADDR_EGR_CNTRS_SAMPLE_CON = 10;
    localparam int ADDR_EGR_CNTRS_READ_SEL   = 11;
    localparam int ADDR_EGR_CNTRS_READ_DATA  = 12;

    localparam int TOTAL_REGS = 13;

    // Bus responses
    localparam reg_resp_t RESP_OKAY        = 2'd0;
    localparam reg_resp_t RESP_SLAVE_ERROR = 2'd2;

    // Counter select word, port above counter index
    localparam int SEL_PORT_MSB = 15;
    localparam int SEL_PORT_LSB = 8;
    localparam int SEL_IDX_MSB  = 7;
    localparam int SEL_IDX_LSB  = 0;

    // Major in the upper byte, minor in the lower
    localparam logic [15:0] MODULE_VERSION = {8'd1, 8'd0};

endpackage

`default_nettype wire

/* hdl/router_stats_pkg.sv */
/* Router statistics types
   Port masks, counter words and per-port counter indices */

`default_nettype none

package router_stats_pkg;

    // Widest enable or sample word
    localparam int MAX_PORTS = 32;

    typedef logic [MAX_PORTS-1:0] port_mask_t;
    typedef logic [31:0]          counter_t;
    typedef logic [7:0]           sel_field_t;

    // Packet, byte and error counts supplied by each port
    localparam int NUM_PROFILE_CNTRS = 3;

    ////////////////////////////////////////////////////////////
    // Counter indices within one port's snapshot
    localparam int PKT_CNT  = 0;
    localparam int BYTE_CNT = 1;
    localparam int ERR_CNT  = 2;

    // Event counters start right after the profile counts
    localparam int FIRST_EVENT_CNT = NUM_PROFILE_CNTRS;

endpackage

`default_nettype wire

/* hdl/router_stats_regs.sv */
/* Router statistics and control register block
   Bus slave plus ingress and egress counter paths */

`default_nettype none
`timescale 1ns/1ps

module router_stats_regs
    import router_regs_pkg::*;
    import router_stats_pkg::*;
#(
    parameter int NUM_ING_PORTS   = 11,
    parameter int NUM_EGR_PORTS   = 11,
    parameter int MTU_BYTES       = 2000,
    parameter int DATA_BYTES      = 64,
    parameter int CLOCK_PERIOD_PS = 10000,
    parameter int MODULE_ID       = 10
) (
    input  wire logic       core_clk_ifc,
    input  wire logic       peripheral_sresetn_core,

    // Register bus
    input  wire reg_addr_t  address,
    input  wire logic       read,
    input  wire logic       write,
    input  wire reg_word_t  writedata,
    output reg_word_t       readdata,
    output logic            readdatavalid,
    output reg_resp_t       response,
    output logic            writeresponsevalid,

    // Ingress
    output port_mask_t      ing_phys_ports_enable,
    input  wire port_mask_t ing_ports_connected,
    input  wire counter_t [NUM_ING_PORTS-1:0][NUM_PROFILE_CNTRS-1:0] ing_profile_cnts,
    input  wire port_mask_t ing_async_fifo_overflow,
    input  wire port_mask_t ing_buf_overflow,

    // Egress
    output port_mask_t      egr_phys_ports_enable,
    input  wire port_mask_t egr_ports_connected,
    input  wire counter_t [NUM_EGR_PORTS-1:0][NUM_PROFILE_CNTRS-1:0] egr_profile_cnts,
    input  wire port_mask_t egr_buf_full_drop
);

    localparam int NUM_ING_EVENTS = 2;
    localparam int NUM_EGR_EVENTS = 1;

    port_mask_t ing_sample;
    port_mask_t egr_sample;
    reg_word_t  ing_read_sel;
    reg_word_t  egr_read_sel;
    counter_t   ing_read_data;
    counter_t   egr_read_data;
    port_mask_t ing_sample_stb;
    port_mask_t egr_sample_stb;

    counter_t [NUM_ING_PORTS-1:0][NUM_ING_EVENTS-1:0] ing_event_counts;
    counter_t [NUM_EGR_PORTS-1:0][NUM_EGR_EVENTS-1:0] egr_event_counts;

    ////////////////////////////////////////////////////////////
    // Bus slave
    router_csr_slave #(
        .NUM_ING_PORTS   ( NUM_ING_PORTS   ),
        .NUM_EGR_PORTS   ( NUM_EGR_PORTS   ),
        .MTU_BYTES       ( MTU_BYTES       ),
        .DATA_BYTES      ( DATA_BYTES      ),
        .CLOCK_PERIOD_PS ( CLOCK_PERIOD_PS ),
        .MODULE_ID       ( MODULE_ID       )
    ) csr_slave (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .address                 ( address                 ),
        .read                    ( read                    ),
        .write                   ( write                   ),
        .writedata               ( writedata               ),
        .readdata                ( readdata                ),
        .readdatavalid           ( readdatavalid           ),
        .response                ( response                ),
        .writeresponsevalid      ( writeresponsevalid      ),
        .ing_phys_ports_enable   ( ing_phys_ports_enable   ),
        .egr_phys_ports_enable   ( egr_phys_ports_enable   ),
        .ing_ports_connected     ( ing_ports_connected     ),
        .egr_ports_connected     ( egr_ports_connected     ),
        .ing_sample              ( ing_sample              ),
        .ing_read_sel            ( ing_read_sel            ),
        .ing_read_data           ( ing_read_data           ),
        .egr_sample              ( egr_sample              ),
        .egr_read_sel            ( egr_read_sel            ),
        .egr_read_data           ( egr_read_data           )
    );

    ////////////////////////////////////////////////////////////
    // Ingress path, async FIFO overflow is event 0
    port_event_counters #(
        .NUM_PORTS  ( NUM_ING_PORTS  ),
        .NUM_EVENTS ( NUM_ING_EVENTS )
    ) ing_event_counters (
        .core_clk_ifc            ( core_clk_ifc                                ),
        .peripheral_sresetn_core ( peripheral_sresetn_core                     ),
        .events                  ( {ing_buf_overflow, ing_async_fifo_overflow} ),
        .sample_stb              ( ing_sample_stb                              ),
        .event_counts            ( ing_event_counts                            )
    );

    counter_snapshot #(
        .NUM_PORTS  ( NUM_ING_PORTS  ),
        .NUM_EVENTS ( NUM_ING_EVENTS )
    ) ing_snapshot (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample                  ( ing_sample              ),
        .read_sel                ( ing_read_sel            ),
        .profile_cnts            ( ing_profile_cnts        ),
        .event_counts            ( ing_event_counts        ),
        .sample_stb              ( ing_sample_stb          ),
        .read_data               ( ing_read_data           )
    );

    ////////////////////////////////////////////////////////////
    // Egress path
    port_event_counters #(
        .NUM_PORTS  ( NUM_EGR_PORTS  ),
        .NUM_EVENTS ( NUM_EGR_EVENTS )
    ) egr_event_counters (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .events                  ( egr_buf_full_drop       ),
        .sample_stb              ( egr_sample_stb          ),
        .event_counts            ( egr_event_counts        )
    );

    counter_snapshot #(
        .NUM_PORTS  ( NUM_EGR_PORTS  ),
        .NUM_EVENTS ( NUM_EGR_EVENTS )
    ) egr_snapshot (
        .core_clk_ifc            ( core_clk_ifc            ),
        .peripheral_sresetn_core ( peripheral_sresetn_core ),
        .sample                  ( egr_sample              ),
        .read_sel                ( egr_read_sel            ),
        .profile_cnts            ( egr_profile_cnts        ),
        .event_counts            ( egr_event_counts        ),
        .sample_stb              ( egr_sample_stb          ),
        .read_data               ( egr_read_data           )
    );

endmodule

`default_nettype wire

/* verilog.f */
+incdir+dv
hdl/router_regs_pkg.sv
hdl/router_stats_pkg.sv
hdl/router_csr_slave.sv
hdl/port_event_counters.sv
hdl/counter_snapshot.sv
hdl/router_stats_regs.sv
dv/router_stats_regs_tb.sv
